// ==== hdl/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// core wide constants of the rv32i core

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// ebreak is matched on the whole word
// funct12 = 1, rs1 = 0, funct3 = 0, rd = 0
`define RV_EBREAK 32'h0010_0073

// byte distance between consecutive instructions
`define RV_PC_STEP 32'd4

`endif

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

	// plain data word, also used for pc and instruction
	typedef logic [31:0] word_t;

	// register index, x0 to x31
	typedef logic [4:0] reg_addr_t;

	// funct3 field
	typedef logic [2:0] funct3_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_e;

	// funct3 of op and op_imm
	localparam funct3_t f3_add_sub = 3'b000;
	localparam funct3_t f3_sll     = 3'b001;
	localparam funct3_t f3_slt     = 3'b010;
	localparam funct3_t f3_sltu    = 3'b011;
	localparam funct3_t f3_xor     = 3'b100;
	localparam funct3_t f3_srl_sra = 3'b101;
	localparam funct3_t f3_or      = 3'b110;
	localparam funct3_t f3_and     = 3'b111;

	// funct3 of branch and jalr
	localparam funct3_t f3_beq  = 3'b000;
	localparam funct3_t f3_bne  = 3'b001;
	localparam funct3_t f3_jalr = 3'b000;

endpackage

// ==== hdl/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

	// alu function, pass_b serves lui
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_e;

	// first alu operand
	typedef enum logic {src_a_rs1, src_a_pc} src_a_e;

	// second alu operand
	typedef enum logic {src_b_rs2, src_b_imm} src_b_e;

	// where the next pc comes from
	typedef enum logic [1:0] {
		pc_step   = 2'd0,
		pc_jal    = 2'd1,
		pc_jalr   = 2'd2,
		pc_branch = 2'd3
	} pc_src_e;

	// branch condition
	typedef enum logic {br_eq, br_ne} br_kind_e;

	// writeback value
	typedef enum logic {wb_alu, wb_pc4} wb_sel_e;

	// core run state
	typedef enum logic {st_running, st_halted} run_state_e;

endpackage

// ==== hdl/rv_pc_unit.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_pc_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              is_ebreak_i,
	input  logic              taken_i,
	input  rv_isa_pkg::word_t target_pc_i,
	output rv_isa_pkg::word_t pc_o,
	output logic              halted_o
);

	rv_ctrl_pkg::run_state_e state;
	rv_isa_pkg::word_t       pc_next;

	// sequential successor or redirect
	assign pc_next = taken_i ? target_pc_i : pc_o + `RV_PC_STEP;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= rv_ctrl_pkg::st_running;
			pc_o  <= `RV_RESET_PC;
		end else begin
			case (state)
				rv_ctrl_pkg::st_running: begin
					// ebreak parks the pc on itself
					if (is_ebreak_i) begin
						state <= rv_ctrl_pkg::st_halted;
					end else begin
						pc_o <= pc_next;
					end
				end
				// only reset leaves halted
				default: begin
					state <= rv_ctrl_pkg::st_halted;
				end
			endcase
		end
	end

	assign halted_o = (state == rv_ctrl_pkg::st_halted);

	// fetch address must stay word aligned
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!rst)
		pc_o[1:0] == 2'b00
	);

	// no fetch progress once halted
	a_pc_frozen: assert property (
		@(posedge clk) disable iff (!rst)
		halted_o |=> $stable(pc_o)
	);

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_isa_pkg::reg_addr_t raddr1_i,
	input  rv_isa_pkg::reg_addr_t raddr2_i,
	output rv_isa_pkg::word_t     rdata1_o,
	output rv_isa_pkg::word_t     rdata2_o,
	input  logic                  wen_i,
	input  rv_isa_pkg::reg_addr_t waddr_i,
	input  rv_isa_pkg::word_t     wdata_i
);

	// x0 has no storage
	rv_isa_pkg::word_t regs [1:`RV_NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 1; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// async reads, x0 forced to zero
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

	// a write aimed at x0 leaves its read value at zero
	a_x0_zero: assert property (
		@(posedge clk) disable iff (!rst)
		(wen_i && (waddr_i == '0))
		|=> ((raddr1_i != '0) || (rdata1_o == '0)) && ((raddr2_i != '0) || (rdata2_o == '0))
	);

endmodule

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decoder (
	input  rv_isa_pkg::word_t      inst_i,
	output rv_isa_pkg::reg_addr_t  raddr1_o,
	output rv_isa_pkg::reg_addr_t  raddr2_o,
	output rv_ctrl_pkg::src_a_e    src_a_o,
	output rv_ctrl_pkg::src_b_e    src_b_o,
	output rv_ctrl_pkg::alu_op_e   alu_op_o,
	output rv_isa_pkg::word_t      imm_o,
	output rv_ctrl_pkg::br_kind_e  br_kind_o,
	output rv_ctrl_pkg::pc_src_e   pc_src_o,
	output rv_ctrl_pkg::wb_sel_e   wb_sel_o,
	output logic                   rd_wen_o,
	output rv_isa_pkg::reg_addr_t  rd_addr_o,
	output logic                   invalid_o,
	output logic                   is_ebreak_o
);

	// funct7 of the base and the alternate (sub, sra) forms
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	rv_isa_pkg::opcode_e opcode;
	rv_isa_pkg::funct3_t funct3;
	logic [6:0]          funct7;
	rv_isa_pkg::word_t   imm_i_type;
	rv_isa_pkg::word_t   imm_u_type;
	rv_isa_pkg::word_t   imm_j_type;
	rv_isa_pkg::word_t   imm_b_type;

	assign opcode = rv_isa_pkg::opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	// register fields sit at fixed positions
	assign raddr1_o  = inst_i[19:15];
	assign raddr2_o  = inst_i[24:20];
	assign rd_addr_o = inst_i[11:7];

	// immediate formats, all sign extended from bit 31
	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u_type = {inst_i[31:12], 12'b0};
	assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

	always_comb begin
		src_a_o     = rv_ctrl_pkg::src_a_rs1;
		src_b_o     = rv_ctrl_pkg::src_b_rs2;
		alu_op_o    = rv_ctrl_pkg::alu_add;
		imm_o       = '0;
		br_kind_o   = rv_ctrl_pkg::br_eq;
		pc_src_o    = rv_ctrl_pkg::pc_step;
		wb_sel_o    = rv_ctrl_pkg::wb_alu;
		rd_wen_o    = 1'b0;
		invalid_o   = 1'b0;
		is_ebreak_o = 1'b0;
		case (opcode)
			rv_isa_pkg::opc_lui: begin
				imm_o    = imm_u_type;
				src_b_o  = rv_ctrl_pkg::src_b_imm;
				alu_op_o = rv_ctrl_pkg::alu_pass_b;
				rd_wen_o = 1'b1;
			end
			rv_isa_pkg::opc_auipc: begin
				imm_o    = imm_u_type;
				src_a_o  = rv_ctrl_pkg::src_a_pc;
				src_b_o  = rv_ctrl_pkg::src_b_imm;
				rd_wen_o = 1'b1;
			end
			rv_isa_pkg::opc_jal: begin
				imm_o    = imm_j_type;
				pc_src_o = rv_ctrl_pkg::pc_jal;
				wb_sel_o = rv_ctrl_pkg::wb_pc4;
				rd_wen_o = 1'b1;
			end
			rv_isa_pkg::opc_jalr: begin
				imm_o     = imm_i_type;
				pc_src_o  = rv_ctrl_pkg::pc_jalr;
				wb_sel_o  = rv_ctrl_pkg::wb_pc4;
				rd_wen_o  = 1'b1;
				invalid_o = (funct3 != rv_isa_pkg::f3_jalr);
			end
			rv_isa_pkg::opc_branch: begin
				imm_o     = imm_b_type;
				pc_src_o  = rv_ctrl_pkg::pc_branch;
				// only beq and bne
				br_kind_o = (funct3 == rv_isa_pkg::f3_bne) ? rv_ctrl_pkg::br_ne : rv_ctrl_pkg::br_eq;
				invalid_o = (funct3 != rv_isa_pkg::f3_beq) && (funct3 != rv_isa_pkg::f3_bne);
			end
			rv_isa_pkg::opc_op_imm: begin
				imm_o    = imm_i_type;
				src_b_o  = rv_ctrl_pkg::src_b_imm;
				rd_wen_o = 1'b1;
				case (funct3)
					rv_isa_pkg::f3_add_sub: alu_op_o = rv_ctrl_pkg::alu_add;
					rv_isa_pkg::f3_slt:     alu_op_o = rv_ctrl_pkg::alu_slt;
					rv_isa_pkg::f3_sltu:    alu_op_o = rv_ctrl_pkg::alu_sltu;
					rv_isa_pkg::f3_xor:     alu_op_o = rv_ctrl_pkg::alu_xor;
					rv_isa_pkg::f3_or:      alu_op_o = rv_ctrl_pkg::alu_or;
					rv_isa_pkg::f3_and:     alu_op_o = rv_ctrl_pkg::alu_and;
					rv_isa_pkg::f3_sll: begin
						alu_op_o  = rv_ctrl_pkg::alu_sll;
						invalid_o = (funct7 != f7_base);
					end
					default: begin
						// srli or srai, picked by funct7
						alu_op_o  = (funct7 == f7_alt) ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
						invalid_o = (funct7 != f7_base) && (funct7 != f7_alt);
					end
				endcase
			end
			rv_isa_pkg::opc_op: begin
				rd_wen_o = 1'b1;
				case (funct3)
					rv_isa_pkg::f3_add_sub: alu_op_o = (funct7 == f7_alt) ? rv_ctrl_pkg::alu_sub : rv_ctrl_pkg::alu_add;
					rv_isa_pkg::f3_sll:     alu_op_o = rv_ctrl_pkg::alu_sll;
					rv_isa_pkg::f3_slt:     alu_op_o = rv_ctrl_pkg::alu_slt;
					rv_isa_pkg::f3_sltu:    alu_op_o = rv_ctrl_pkg::alu_sltu;
					rv_isa_pkg::f3_xor:     alu_op_o = rv_ctrl_pkg::alu_xor;
					rv_isa_pkg::f3_srl_sra: alu_op_o = (funct7 == f7_alt) ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
					rv_isa_pkg::f3_or:      alu_op_o = rv_ctrl_pkg::alu_or;
					default:                alu_op_o = rv_ctrl_pkg::alu_and;
				endcase
				// alt funct7 only exists for sub and sra
				invalid_o = !((funct7 == f7_base) || ((funct7 == f7_alt) &&
					((funct3 == rv_isa_pkg::f3_add_sub) || (funct3 == rv_isa_pkg::f3_srl_sra))));
			end
			rv_isa_pkg::opc_system: begin
				// ecall and csr ops are not supported
				is_ebreak_o = (inst_i == `RV_EBREAK);
				invalid_o   = !is_ebreak_o;
			end
			default: begin
				invalid_o = 1'b1;
			end
		endcase
		// invalid retires as a plain step with no write
		if (invalid_o) begin
			rd_wen_o = 1'b0;
			pc_src_o = rv_ctrl_pkg::pc_step;
		end
	end

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_execute (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  halted_i,
	input  rv_isa_pkg::word_t     pc_i,
	input  rv_isa_pkg::word_t     rdata1_i,
	input  rv_isa_pkg::word_t     rdata2_i,
	input  rv_ctrl_pkg::src_a_e   src_a_i,
	input  rv_ctrl_pkg::src_b_e   src_b_i,
	input  rv_ctrl_pkg::alu_op_e  alu_op_i,
	input  rv_isa_pkg::word_t     imm_i,
	input  rv_ctrl_pkg::br_kind_e br_kind_i,
	input  rv_ctrl_pkg::pc_src_e  pc_src_i,
	input  rv_ctrl_pkg::wb_sel_e  wb_sel_i,
	input  logic                  rd_wen_i,
	input  rv_isa_pkg::reg_addr_t rd_addr_i,
	output logic                  taken_o,
	output rv_isa_pkg::word_t     target_pc_o,
	output logic                  wb_en_o,
	output rv_isa_pkg::reg_addr_t wb_addr_o,
	output rv_isa_pkg::word_t     wb_data_o
);

	rv_isa_pkg::word_t op_a;
	rv_isa_pkg::word_t op_b;
	rv_isa_pkg::word_t alu_res;
	rv_isa_pkg::word_t jalr_sum;
	logic              br_cond;

	assign op_a = (src_a_i == rv_ctrl_pkg::src_a_pc) ? pc_i : rdata1_i;
	assign op_b = (src_b_i == rv_ctrl_pkg::src_b_imm) ? imm_i : rdata2_i;

	// shifts use only the low five bits of op_b
	always_comb begin
		case (alu_op_i)
			rv_ctrl_pkg::alu_sub:  alu_res = op_a - op_b;
			rv_ctrl_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
			rv_ctrl_pkg::alu_slt:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_ctrl_pkg::alu_sltu: alu_res = {31'b0, op_a < op_b};
			rv_ctrl_pkg::alu_xor:  alu_res = op_a ^ op_b;
			rv_ctrl_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
			rv_ctrl_pkg::alu_sra:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
			rv_ctrl_pkg::alu_or:   alu_res = op_a | op_b;
			rv_ctrl_pkg::alu_and:  alu_res = op_a & op_b;
			rv_ctrl_pkg::alu_pass_b: alu_res = op_b;
			default:               alu_res = op_a + op_b;
		endcase
	end

	// beq or bne on the raw register values
	assign br_cond = (br_kind_i == rv_ctrl_pkg::br_ne) ? (rdata1_i != rdata2_i) :
		(rdata1_i == rdata2_i);

	// jalr drops bit 0 of the sum
	assign jalr_sum    = rdata1_i + imm_i;
	assign target_pc_o = (pc_src_i == rv_ctrl_pkg::pc_jalr) ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;

	always_comb begin
		case (pc_src_i)
			rv_ctrl_pkg::pc_jal:    taken_o = 1'b1;
			rv_ctrl_pkg::pc_jalr:   taken_o = 1'b1;
			rv_ctrl_pkg::pc_branch: taken_o = br_cond;
			default:                taken_o = 1'b0;
		endcase
	end

	// writeback doubles as the commit trace
	assign wb_en_o   = rd_wen_i && rst && !halted_i;
	assign wb_addr_o = rd_addr_i;
	assign wb_data_o = (wb_sel_i == rv_ctrl_pkg::wb_pc4) ? pc_i + `RV_PC_STEP : alu_res;

	// no commit while halted nor in the ebreak cycle before it
	a_no_commit_halted: assert property (
		@(posedge clk) disable iff (!rst)
		halted_i |-> !wb_en_o && !$past(wb_en_o)
	);

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_isa_pkg::word_t     inst_i,
	output rv_isa_pkg::word_t     pc_o,
	output logic                  invalid_o,
	output logic                  halted_o,
	output logic                  wb_en_o,
	output rv_isa_pkg::reg_addr_t wb_addr_o,
	output rv_isa_pkg::word_t     wb_data_o
);

	// register file reads
	rv_isa_pkg::reg_addr_t raddr1;
	rv_isa_pkg::reg_addr_t raddr2;
	rv_isa_pkg::word_t     rdata1;
	rv_isa_pkg::word_t     rdata2;

	// decode to execute
	rv_ctrl_pkg::src_a_e   src_a;
	rv_ctrl_pkg::src_b_e   src_b;
	rv_ctrl_pkg::alu_op_e  alu_op;
	rv_isa_pkg::word_t     imm;
	rv_ctrl_pkg::br_kind_e br_kind;
	rv_ctrl_pkg::pc_src_e  pc_src;
	rv_ctrl_pkg::wb_sel_e  wb_sel;
	logic                  rd_wen;
	rv_isa_pkg::reg_addr_t rd_addr;
	logic                  is_ebreak;

	// redirect back to the pc
	logic                  taken;
	rv_isa_pkg::word_t     target_pc;

	rv_pc_unit rv_pc_unit_i (
		.clk         (clk),
		.rst         (rst),
		.is_ebreak_i (is_ebreak),
		.taken_i     (taken),
		.target_pc_i (target_pc),
		.pc_o        (pc_o),
		.halted_o    (halted_o)
	);

	rv_decoder rv_decoder_i (
		.inst_i      (inst_i),
		.raddr1_o    (raddr1),
		.raddr2_o    (raddr2),
		.src_a_o     (src_a),
		.src_b_o     (src_b),
		.alu_op_o    (alu_op),
		.imm_o       (imm),
		.br_kind_o   (br_kind),
		.pc_src_o    (pc_src),
		.wb_sel_o    (wb_sel),
		.rd_wen_o    (rd_wen),
		.rd_addr_o   (rd_addr),
		.invalid_o   (invalid_o),
		.is_ebreak_o (is_ebreak)
	);

	// writeback lands here at the edge
	rv_regfile rv_regfile_i (
		.clk      (clk),
		.rst      (rst),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wen_i    (wb_en_o),
		.waddr_i  (wb_addr_o),
		.wdata_i  (wb_data_o)
	);

	rv_execute rv_execute_i (
		.clk         (clk),
		.rst         (rst),
		.halted_i    (halted_o),
		.pc_i        (pc_o),
		.rdata1_i    (rdata1),
		.rdata2_i    (rdata2),
		.src_a_i     (src_a),
		.src_b_i     (src_b),
		.alu_op_i    (alu_op),
		.imm_i       (imm),
		.br_kind_i   (br_kind),
		.pc_src_i    (pc_src),
		.wb_sel_i    (wb_sel),
		.rd_wen_i    (rd_wen),
		.rd_addr_i   (rd_addr),
		.taken_o     (taken),
		.target_pc_o (target_pc),
		.wb_en_o     (wb_en_o),
		.wb_addr_o   (wb_addr_o),
		.wb_data_o   (wb_data_o)
	);

endmodule

// ==== test/tb_rv_tasks.svh ====
`ifndef TB_RV_TASKS_SVH
`define TB_RV_TASKS_SVH

task automatic check_value(input string name, input rv_isa_pkg::word_t actual,
		input rv_isa_pkg::word_t expected);
	if (actual !== expected) begin
		$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
		$display("RESULT: FAIL");
		$fatal(1, "mismatch on %s", name);
	end
endtask

// instruction encoders
function automatic rv_isa_pkg::word_t encode_r(input logic [6:0] f7,
		input rv_isa_pkg::reg_addr_t rs2, input rv_isa_pkg::reg_addr_t rs1,
		input logic [2:0] f3, input rv_isa_pkg::reg_addr_t rd);
	return {f7, rs2, rs1, f3, rd, opc_op};
endfunction

function automatic rv_isa_pkg::word_t encode_i(input logic [11:0] imm,
		input rv_isa_pkg::reg_addr_t rs1, input logic [2:0] f3,
		input rv_isa_pkg::reg_addr_t rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_isa_pkg::word_t encode_u(input logic [19:0] imm,
		input rv_isa_pkg::reg_addr_t rd, input logic [6:0] opc);
	return {imm, rd, opc};
endfunction

function automatic rv_isa_pkg::word_t encode_j(input logic [20:0] off,
		input rv_isa_pkg::reg_addr_t rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
endfunction

function automatic rv_isa_pkg::word_t encode_b(input logic [12:0] off,
		input rv_isa_pkg::reg_addr_t rs2, input rv_isa_pkg::reg_addr_t rs1,
		input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
endfunction

function automatic rv_isa_pkg::reg_addr_t pick_reg(input int unsigned lo, input int unsigned hi);
	int unsigned r;
	r = $urandom_range(hi, lo);
	return r[4:0];
endfunction

task automatic clear_program;
	for (int i = 0; i < prog_depth; i++) begin
		prog[i] = fill_word(`RV_RESET_PC + (i << 2));
	end
	prog_len = 0;
endtask

task automatic emit(input rv_isa_pkg::word_t w);
	prog[prog_len] = w;
	prog_len = prog_len + 1;
endtask

// nops into x0 still show up on the commit trace
task automatic test_reset;
	clear_program();
	emit(encode_i(12'd0, 5'd0, 3'd0, 5'd0, opc_op_imm));
	emit(encode_i(12'd0, 5'd0, 3'd0, 5'd0, opc_op_imm));
	apply_reset();
	run_cycles(steps_reset);
endtask

task automatic test_alu;
	int                k;
	rv_isa_pkg::word_t r;
	logic [2:0]        f3;
	logic [6:0]        f7;
	clear_program();
	// random x1 to x6 via lui then addi
	for (k = 1; k <= 6; k++) begin
		r = $urandom();
		emit(encode_u(r[31:12], k[4:0], opc_lui));
		emit(encode_i(r[11:0], k[4:0], 3'd0, k[4:0], opc_op_imm));
	end
	// register-register ops with k 8 and 9 as sub and sra
	for (k = 0; k < 10; k++) begin
		f3 = (k == 8) ? 3'd0 : (k == 9) ? 3'd5 : k[2:0];
		f7 = (k >= 8) ? 7'h20 : 7'h00;
		emit(encode_r(f7, pick_reg(1, 6), pick_reg(1, 6), f3, pick_reg(7, 15)));
	end
	// register-immediate ops where shifts carry funct7 in imm[11:5]
	for (k = 0; k < 9; k++) begin
		r = $urandom();
		f3 = (k == 8) ? 3'd5 : k[2:0];
		if (f3 == 3'd1 || f3 == 3'd5) begin
			r[11:5] = (k == 8) ? 7'h20 : 7'h00;
		end
		emit(encode_i(r[11:0], pick_reg(1, 6), f3, pick_reg(7, 15), opc_op_imm));
	end
	// result into x0 is dropped and x0 is then read as an operand
	emit(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
	emit(encode_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd7));
	apply_reset();
	run_cycles(steps_alu);
endtask

task automatic test_jumps;
	rv_isa_pkg::word_t r;
	rv_isa_pkg::word_t base;
	clear_program();
	r    = $urandom();
	base = `RV_RESET_PC;
	emit(encode_u(r[31:12], 5'd1, opc_auipc));
	emit(encode_j(21'd8, 5'd2));
	emit(encode_i(12'd1, 5'd0, 3'd0, 5'd3, opc_op_imm));
	emit(encode_u(base[31:12], 5'd5, opc_lui));
	// odd offset whose target lands on word 6
	emit(encode_i(12'd25, 5'd5, 3'd0, 5'd6, opc_jalr));
	emit(encode_i(12'd2, 5'd0, 3'd0, 5'd3, opc_op_imm));
	emit(encode_j(21'd8, 5'd7));
	emit(encode_i(12'd3, 5'd0, 3'd0, 5'd3, opc_op_imm));
	// back to word 2
	emit(encode_i(12'd8, 5'd5, 3'd0, 5'd8, opc_jalr));
	apply_reset();
	run_cycles(steps_jump);
endtask

task automatic test_branches;
	rv_isa_pkg::word_t r;
	clear_program();
	r = $urandom();
	emit(encode_u(r[31:12], 5'd1, opc_lui));
	emit(encode_i(12'd0, 5'd1, 3'd0, 5'd2, opc_op_imm));
	emit(encode_i(12'd1, 5'd1, 3'd0, 5'd3, opc_op_imm));
	// beq equal, then beq unequal
	emit(encode_b(13'd8, 5'd2, 5'd1, 3'd0));
	emit(encode_i(12'd1, 5'd0, 3'd0, 5'd4, opc_op_imm));
	emit(encode_b(13'd8, 5'd3, 5'd1, 3'd0));
	// bne unequal, then bne equal
	emit(encode_b(13'd8, 5'd3, 5'd1, 3'd1));
	emit(encode_i(12'd2, 5'd0, 3'd0, 5'd5, opc_op_imm));
	emit(encode_b(13'd8, 5'd2, 5'd1, 3'd1));
	// backward beq to word 6
	emit(encode_b(13'h1ff4, 5'd0, 5'd0, 3'd0));
	apply_reset();
	run_cycles(steps_branch);
endtask

task automatic test_invalid;
	clear_program();
	emit(encode_i(12'd0, 5'd1, 3'd2, 5'd3, opc_load));
	emit(encode_i(12'h300, 5'd1, 3'd1, 5'd3, opc_system));
	emit(encode_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));
	emit(encode_b(13'd8, 5'd2, 5'd1, 3'd4));
	// slli with the sra funct7
	emit(encode_i(12'h401, 5'd1, 3'd1, 5'd3, opc_op_imm));
	emit(encode_i(12'd5, 5'd0, 3'd0, 5'd1, opc_op_imm));
	apply_reset();
	run_cycles(steps_invalid);
endtask

task automatic test_halt;
	rv_isa_pkg::word_t r;
	clear_program();
	r = $urandom();
	emit(encode_i(r[11:0], 5'd0, 3'd0, 5'd1, opc_op_imm));
	emit(`RV_EBREAK);
	emit(encode_i(12'd1, 5'd0, 3'd0, 5'd2, opc_op_imm));
	apply_reset();
	// addi then the ebreak that halts the core
	run_cycles(2);
	// parked word becomes an addi that a running core would commit and step past
	prog[1] = encode_i(12'd9, 5'd0, 3'd0, 5'd3, opc_op_imm);
	run_cycles(steps_halt - 2);
	// only reset leaves halt
	apply_reset();
	run_cycles(steps_restart);
endtask

`endif

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;

	localparam int reset_cycles = 3;
	localparam int prog_depth   = 64;

	// retired instructions per test with the idle halt cycles counted
	localparam int steps_reset   = 2;
	localparam int steps_alu     = 33;
	localparam int steps_jump    = 7;
	localparam int steps_branch  = 10;
	localparam int steps_invalid = 6;
	localparam int steps_halt    = 7;
	localparam int steps_restart = 2;
	localparam int num_resets    = 7;
	localparam int total_steps   = steps_reset + steps_alu + steps_jump + steps_branch +
		steps_invalid + steps_halt + steps_restart;
	localparam int timeout_cycles = 2 * total_steps + num_resets * reset_cycles;

	// raw opcodes
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_system = 7'b1110011;
	localparam logic [6:0] opc_load   = 7'b0000011;

	logic                  clk;
	logic                  rst;
	rv_isa_pkg::word_t     inst;
	rv_isa_pkg::word_t     pc;
	logic                  invalid;
	logic                  halted;
	logic                  wb_en;
	rv_isa_pkg::reg_addr_t wb_addr;
	rv_isa_pkg::word_t     wb_data;

	// program memory indexed by word from the reset pc
	rv_isa_pkg::word_t prog [0:prog_depth-1];
	rv_isa_pkg::word_t fetch_idx;
	int                prog_len;
	int                cycle_count = 0;

	// reference model state
	rv_isa_pkg::word_t     model_regs [0:31];
	rv_isa_pkg::word_t     model_pc;
	logic                  model_halted;

	// expected response for the instruction at model_pc
	logic                  exp_wen;
	logic                  exp_invalid;
	logic                  exp_halt;
	rv_isa_pkg::reg_addr_t exp_waddr;
	rv_isa_pkg::word_t     exp_wdata;
	rv_isa_pkg::word_t     exp_next_pc;

	rv_core_top rv_core_top_i (
		.clk       (clk),
		.rst       (rst),
		.inst_i    (inst),
		.pc_o      (pc),
		.invalid_o (invalid),
		.halted_o  (halted),
		.wb_en_o   (wb_en),
		.wb_addr_o (wb_addr),
		.wb_data_o (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// unloaded words hold a load that this core rejects
	function automatic rv_isa_pkg::word_t fill_word(input rv_isa_pkg::word_t addr);
		return {addr[31:7] ^ addr[24:0], opc_load};
	endfunction

	function automatic rv_isa_pkg::word_t mem_read(input rv_isa_pkg::word_t addr);
		rv_isa_pkg::word_t idx;
		idx = (addr - `RV_RESET_PC) >> 2;
		if (idx < prog_depth) begin
			return prog[idx[5:0]];
		end
		return fill_word(addr);
	endfunction

	// combinational fetch
	assign fetch_idx = (pc - `RV_RESET_PC) >> 2;
	assign inst = (fetch_idx < prog_depth) ? prog[fetch_idx[5:0]] : fill_word(pc);

	function automatic rv_isa_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
			input rv_isa_pkg::word_t a, input rv_isa_pkg::word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic model_reset;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		model_pc     = `RV_RESET_PC;
		model_halted = 1'b0;
	endtask

	// ISA rules for the kept subset
	task automatic model_predict(input rv_isa_pkg::word_t ins);
		rv_isa_pkg::word_t a;
		rv_isa_pkg::word_t b;
		rv_isa_pkg::word_t imm_i;
		rv_isa_pkg::word_t imm_b;
		rv_isa_pkg::word_t imm_j;
		logic [2:0]        f3;
		logic [6:0]        f7;
		f3          = ins[14:12];
		f7          = ins[31:25];
		a           = model_regs[ins[19:15]];
		b           = model_regs[ins[24:20]];
		imm_i       = {{20{ins[31]}}, ins[31:20]};
		imm_b       = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j       = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		exp_wen     = 1'b0;
		exp_invalid = 1'b0;
		exp_halt    = 1'b0;
		exp_waddr   = ins[11:7];
		exp_wdata   = '0;
		exp_next_pc = model_pc + `RV_PC_STEP;
		case (ins[6:0])
			opc_lui: begin
				exp_wen   = 1'b1;
				exp_wdata = {ins[31:12], 12'b0};
			end
			opc_auipc: begin
				exp_wen   = 1'b1;
				exp_wdata = model_pc + {ins[31:12], 12'b0};
			end
			opc_jal: begin
				exp_wen     = 1'b1;
				exp_wdata   = model_pc + `RV_PC_STEP;
				exp_next_pc = model_pc + imm_j;
			end
			opc_jalr: begin
				if (f3 == 3'd0) begin
					exp_wen     = 1'b1;
					exp_wdata   = model_pc + `RV_PC_STEP;
					exp_next_pc = (a + imm_i) & ~32'd1;
				end else begin
					exp_invalid = 1'b1;
				end
			end
			opc_branch: begin
				// beq taken on equal, bne on unequal
				if (f3 == 3'd0 || f3 == 3'd1) begin
					if ((a == b) != f3[0]) begin
						exp_next_pc = model_pc + imm_b;
					end
				end else begin
					exp_invalid = 1'b1;
				end
			end
			opc_op_imm: begin
				if ((f3 == 3'd1 && f7 != 7'h00) ||
					(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
					exp_invalid = 1'b1;
				end else begin
					exp_wen   = 1'b1;
					exp_wdata = alu_model(f3, (f3 == 3'd5) && (f7 == 7'h20), a, imm_i);
				end
			end
			opc_op: begin
				if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
					exp_wen   = 1'b1;
					exp_wdata = alu_model(f3, f7[5], a, b);
				end else begin
					exp_invalid = 1'b1;
				end
			end
			opc_system: begin
				if (ins == `RV_EBREAK) begin
					exp_halt = 1'b1;
				end else begin
					exp_invalid = 1'b1;
				end
			end
			default: exp_invalid = 1'b1;
		endcase
		// ebreak and halted both park the pc
		if (exp_halt || model_halted) begin
			exp_wen     = 1'b0;
			exp_next_pc = model_pc;
		end
	endtask

	task automatic model_commit;
		if (exp_wen && exp_waddr != 5'd0) begin
			model_regs[exp_waddr] = exp_wdata;
		end
		model_pc = exp_next_pc;
		if (exp_halt) begin
			model_halted = 1'b1;
		end
	endtask

	// called at edge plus 1 ns and returns at the same phase
	task automatic apply_reset;
		rst = 1'b0;
		repeat (reset_cycles) begin
			@(posedge clk);
			#1;
			check_value("pc_o", pc, `RV_RESET_PC);
			check_value("halted_o", {31'b0, halted}, 32'd0);
			check_value("wb_en_o", {31'b0, wb_en}, 32'd0);
		end
		rst = 1'b1;
		model_reset();
	endtask

	// compare one instruction's response at the falling edge and retire it at the rising edge
	task automatic run_cycles(input int n);
		repeat (n) begin
			model_predict(mem_read(model_pc));
			@(negedge clk);
			check_value("pc_o", pc, model_pc);
			check_value("halted_o", {31'b0, halted}, {31'b0, model_halted});
			check_value("invalid_o", {31'b0, invalid}, {31'b0, exp_invalid});
			check_value("wb_en_o", {31'b0, wb_en}, {31'b0, exp_wen});
			if (exp_wen) begin
				check_value("wb_addr_o", {27'b0, wb_addr}, {27'b0, exp_waddr});
				check_value("wb_data_o", wb_data, exp_wdata);
			end
			@(posedge clk);
			#1;
			model_commit();
		end
	endtask

	`include "tb_rv_tasks.svh"

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
			$display("RESULT: FAIL");
			$fatal(1, "simulation timeout");
		end
	end

	initial begin
		rst = 1'b0;
		void'($urandom(60));
		test_reset();
		test_alu();
		test_jumps();
		test_branches();
		test_invalid();
		test_halt();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+hdl
+incdir+test
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/rv_pc_unit.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/rv_execute.sv
hdl/rv_core_top.sv
test/tb_rv_core.sv

// ==== Makefile ====
# Verilator simulation of the rv32i core

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, and pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
